//--- sw_defs.svh
`ifndef SW_DEFS_SVH
`define SW_DEFS_SVH

// array size, one PE per query base
`define SW_NUM_PE 8

// signed score width
`define SW_SCORE_W 12

// reference length limit and index width
`define SW_MAX_REF 1023
`define SW_REF_W 10

// scoring, all given as positive magnitudes
`define SW_MATCH 2
`define SW_MISMATCH 1

// gap open includes the first gap base
`define SW_GAP_OPEN 4
`define SW_GAP_EXT 1

`endif

//--- sw_pkg.sv
`include "sw_defs.svh"

package sw_pkg;

    localparam int SW_QIDX_W = (`SW_NUM_PE > 1) ? $clog2(`SW_NUM_PE) : 1;

    typedef logic [1:0] sw_base_t;

    typedef logic signed [`SW_SCORE_W-1:0] sw_score_t;

    typedef logic [SW_QIDX_W-1:0] sw_qidx_t;

    // stands in for unreachable gap states, far enough from the edge to subtract from
    localparam sw_score_t SW_NEG_INF = sw_score_t'(-(2 ** (`SW_SCORE_W - 2)));

    // base 0 goes to PE 0
    typedef sw_base_t [`SW_NUM_PE-1:0] sw_job_t;

    typedef struct packed {
        sw_base_t base;
        logic     last;
    } sw_ref_t;

    // one reference row as seen between neighbouring PEs
    typedef struct packed {
        logic      valid;
        sw_base_t  base;
        sw_score_t h;
        sw_score_t e;
    } sw_link_t;

    typedef struct packed {
        sw_score_t             score;
        logic [`SW_REF_W-1:0]  ref_idx;
        sw_qidx_t              qry_idx;
    } sw_result_t;

endpackage

//--- sw_pe.sv
`include "sw_defs.svh"

module sw_pe (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_adv,
    input  logic              i_clear,
    input  sw_pkg::sw_base_t  i_qbase,
    input  sw_pkg::sw_link_t  i_left,
    output sw_pkg::sw_link_t  o_right,
    output sw_pkg::sw_score_t o_h,
    output logic              o_valid
);
    import sw_pkg::*;

    localparam sw_score_t MATCH    = sw_score_t'(`SW_MATCH);
    localparam sw_score_t MISMATCH = sw_score_t'(`SW_MISMATCH);
    localparam sw_score_t GAP_OPEN = sw_score_t'(`SW_GAP_OPEN);
    localparam sw_score_t GAP_EXT  = sw_score_t'(`SW_GAP_EXT);
    // no cell can score more than a full query match
    localparam sw_score_t H_MAX    = sw_score_t'(`SW_MATCH * `SW_NUM_PE);

    // h_q doubles as the top neighbour for the next row
    logic      vld_q;
    sw_base_t  base_q;
    sw_score_t h_q;
    sw_score_t e_q;
    sw_score_t f_q;
    // left H of the previous row
    sw_score_t diag_q;

    sw_score_t pair_s;
    sw_score_t diag_s;
    sw_score_t e_new;
    sw_score_t f_new;
    sw_score_t h_new;

    function automatic sw_score_t smax(input sw_score_t a, input sw_score_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        pair_s = (i_left.base == i_qbase) ? MATCH : -MISMATCH;
        diag_s = diag_q + pair_s;
        // gap along the query, from the left neighbour
        e_new  = smax(i_left.h - GAP_OPEN, i_left.e - GAP_EXT);
        // gap along the reference, from this column's last row
        f_new  = smax(h_q - GAP_OPEN, f_q - GAP_EXT);
        h_new  = smax(smax(sw_score_t'(0), diag_s), smax(e_new, f_new));
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            vld_q <= 1'b0;
        end else if (i_clear) begin
            vld_q <= 1'b0;
        end else if (i_adv) begin
            vld_q <= i_left.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            // top row boundary
            h_q    <= '0;
            f_q    <= SW_NEG_INF;
            diag_q <= '0;
        end else if (i_adv && i_left.valid) begin
            base_q <= i_left.base;
            h_q    <= h_new;
            e_q    <= e_new;
            f_q    <= f_new;
            diag_q <= i_left.h;
        end
    end

    assign o_right = '{valid: vld_q, base: base_q, h: h_q, e: e_q};
    assign o_h     = h_q;
    assign o_valid = vld_q;

    // local alignment floor at zero, and no wrap past the best possible score
    a_h_nonneg: assert property (@(posedge i_clk) disable iff (i_rst)
        vld_q |-> (h_q >= 0) && (h_q <= H_MAX));

endmodule

//--- sw_peak_finder.sv
`include "sw_defs.svh"

module sw_peak_finder (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_adv,
    input  logic                   i_clear,
    input  sw_pkg::sw_score_t      i_h [`SW_NUM_PE],
    input  logic [`SW_NUM_PE-1:0]  i_valid,
    output sw_pkg::sw_result_t     o_best
);
    import sw_pkg::*;

    localparam int LVLS   = $clog2(`SW_NUM_PE);
    localparam int LEAVES = 1 << LVLS;
    // diagonal steps run past the last row by the array length
    localparam int STEP_W = $clog2(`SW_MAX_REF + `SW_NUM_PE);

    typedef struct packed {
        logic      valid;
        sw_score_t h;
        sw_qidx_t  q;
    } cand_t;

    // heap order, node 1 is the root
    cand_t             node [1:2*LEAVES-1];
    logic              pend_q;
    logic [STEP_W-1:0] step_q;
    logic [STEP_W-1:0] row;
    sw_result_t        best_q;

    always_comb begin
        for (int n = 0; n < `SW_NUM_PE; n++) begin
            node[LEAVES+n] = '{valid: i_valid[n], h: i_h[n], q: sw_qidx_t'(n)};
        end
        for (int n = `SW_NUM_PE; n < LEAVES; n++) begin
            node[LEAVES+n] = '0;
        end
        // lower PE index keeps ties
        for (int n = LEAVES - 1; n >= 1; n--) begin
            if (node[2*n+1].valid && (!node[2*n].valid || node[2*n+1].h > node[2*n].h)) begin
                node[n] = node[2*n+1];
            end else begin
                node[n] = node[2*n];
            end
        end
    end

    // PE j works on row step - j
    assign row = step_q - STEP_W'(node[1].q);

    // PE outputs of a step are looked at one cycle after its advance
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            pend_q <= 1'b0;
            step_q <= '0;
            best_q <= '0;
        end else if (i_clear) begin
            pend_q <= 1'b0;
            step_q <= '0;
            best_q <= '0;
        end else begin
            pend_q <= i_adv;
            if (pend_q) begin
                step_q <= step_q + 1'b1;
                if (node[1].valid && node[1].h > best_q.score) begin
                    best_q.score   <= node[1].h;
                    best_q.ref_idx <= row[`SW_REF_W-1:0];
                    best_q.qry_idx <= node[1].q;
                end
            end
        end
    end

    assign o_best = best_q;

    a_qidx_range: assert property (@(posedge i_clk) disable iff (i_rst)
        best_q.qry_idx < `SW_NUM_PE);

endmodule

//--- sw_ctrl.sv
`include "sw_defs.svh"

module sw_ctrl (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_job_valid,
    output logic               o_job_ready,
    input  sw_pkg::sw_job_t    i_job,
    input  logic               i_ref_valid,
    output logic               o_ref_ready,
    input  sw_pkg::sw_ref_t    i_ref,
    input  sw_pkg::sw_result_t i_best,
    output logic               o_res_valid,
    input  logic               i_res_ready,
    output sw_pkg::sw_result_t o_res,
    output logic               o_adv,
    output logic               o_clear,
    output sw_pkg::sw_job_t    o_query,
    output sw_pkg::sw_link_t   o_head
);
    import sw_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        DONE
    } state_t;

    localparam int DRAIN_W = $clog2(`SW_NUM_PE + 2);
    localparam logic [DRAIN_W-1:0] DRAIN_STEPS = DRAIN_W'(`SW_NUM_PE);
    // the peak register trails the last drain step by one cycle
    localparam logic [DRAIN_W-1:0] DRAIN_LAST  = DRAIN_W'(`SW_NUM_PE + 1);

    state_t             state_q;
    logic [DRAIN_W-1:0] drain_cnt_q;
    logic               clear_q;
    sw_job_t            query_q;
    sw_result_t         res_q;
    logic               job_fire;
    logic               ref_fire;
    logic               res_fire;
    logic               drain_end;

    assign o_job_ready = (state_q == IDLE);
    assign o_ref_ready = (state_q == RUN) && !clear_q;
    assign o_res_valid = (state_q == DONE);

    assign job_fire  = i_job_valid && o_job_ready;
    assign ref_fire  = i_ref_valid && o_ref_ready;
    assign res_fire  = o_res_valid && i_res_ready;
    assign drain_end = (state_q == DRAIN) && (drain_cnt_q == DRAIN_LAST);

    // one step per accepted base, then empty steps to flush the chain
    assign o_adv = ref_fire || ((state_q == DRAIN) && (drain_cnt_q < DRAIN_STEPS));

    // left boundary column: H is zero, no gap open yet
    assign o_head = '{valid: ref_fire, base: i_ref.base, h: '0, e: SW_NEG_INF};

    assign o_clear = clear_q;
    assign o_query = query_q;
    assign o_res   = res_q;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q     <= IDLE;
            drain_cnt_q <= '0;
            clear_q     <= 1'b0;
        end else begin
            clear_q <= job_fire;
            case (state_q)
                IDLE: begin
                    if (job_fire) begin
                        state_q <= RUN;
                    end
                end
                RUN: begin
                    if (ref_fire && i_ref.last) begin
                        state_q     <= DRAIN;
                        drain_cnt_q <= '0;
                    end
                end
                DRAIN: begin
                    drain_cnt_q <= drain_cnt_q + 1'b1;
                    if (drain_end) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (res_fire) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (job_fire) begin
            query_q <= i_job;
        end
        if (drain_end) begin
            res_q <= i_best;
        end
    end

    // never in the clear cycle of a new job
    a_ref_in_run: assert property (@(posedge i_clk) disable iff (i_rst)
        ref_fire |-> (state_q == RUN) && ($past(state_q) == RUN));

endmodule

//--- sw_align_top.sv
`include "sw_defs.svh"

module sw_align_top (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_job_valid,
    output logic               o_job_ready,
    input  sw_pkg::sw_job_t    i_job,
    input  logic               i_ref_valid,
    output logic               o_ref_ready,
    input  sw_pkg::sw_ref_t    i_ref,
    output logic               o_res_valid,
    input  logic               i_res_ready,
    output sw_pkg::sw_result_t o_res
);
    import sw_pkg::*;

    logic                  adv;
    logic                  clear;
    sw_job_t               query;
    sw_result_t            best;
    // link[0] comes from the control block, link[k+1] leaves PE k
    sw_link_t              link [`SW_NUM_PE+1];
    sw_score_t             pe_h [`SW_NUM_PE];
    logic [`SW_NUM_PE-1:0] pe_valid;

    sw_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_job_valid (i_job_valid),
        .o_job_ready (o_job_ready),
        .i_job       (i_job),
        .i_ref_valid (i_ref_valid),
        .o_ref_ready (o_ref_ready),
        .i_ref       (i_ref),
        .i_best      (best),
        .o_res_valid (o_res_valid),
        .i_res_ready (i_res_ready),
        .o_res       (o_res),
        .o_adv       (adv),
        .o_clear     (clear),
        .o_query     (query),
        .o_head      (link[0])
    );

    for (genvar k = 0; k < `SW_NUM_PE; k++) begin : g_pe
        sw_pe u_pe (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_adv   (adv),
            .i_clear (clear),
            .i_qbase (query[k]),
            .i_left  (link[k]),
            .o_right (link[k+1]),
            .o_h     (pe_h[k]),
            .o_valid (pe_valid[k])
        );
    end

    sw_peak_finder u_peak (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_adv   (adv),
        .i_clear (clear),
        .i_h     (pe_h),
        .i_valid (pe_valid),
        .o_best  (best)
    );

endmodule

//--- tb_sw_align.sv
`include "sw_defs.svh"

module tb_sw_align;
    import sw_pkg::*;

    localparam int NPE         = `SW_NUM_PE;
    localparam int RES_LAT     = `SW_NUM_PE + 2;
    localparam int WAIT_LIMIT  = 200;
    localparam int NEG         = -100000;

    logic       i_clk;
    logic       i_rst;
    logic       i_job_valid;
    logic       o_job_ready;
    sw_job_t    i_job;
    logic       i_ref_valid;
    logic       o_ref_ready;
    sw_ref_t    i_ref;
    logic       o_res_valid;
    logic       i_res_ready;
    sw_result_t o_res;

    integer     seed = 32'hff90cc3d;
    sw_base_t   ref_mem [`SW_MAX_REF];
    int         ref_len;
    // high between job acceptance and the last base
    logic       ref_open;

    sw_align_top DUT (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_job_valid (i_job_valid),
        .o_job_ready (o_job_ready),
        .i_job       (i_job),
        .i_ref_valid (i_ref_valid),
        .o_ref_ready (o_ref_ready),
        .i_ref       (i_ref),
        .o_res_valid (o_res_valid),
        .i_res_ready (i_res_ready),
        .o_res       (o_res)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_int(input string what, input int got, input int exp);
        assert (got == exp) else
            fail_run($sformatf("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic tick();
        @(posedge i_clk);
        #1;
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int imax(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    function automatic sw_job_t random_query();
        sw_job_t q;
        for (int k = 0; k < NPE; k++) begin
            q[k] = sw_base_t'(rand_below(4));
        end
        return q;
    endfunction

    // bases drawn from lo .. lo+span-1
    task automatic fill_ref(input int len, input int lo, input int span);
        ref_len = len;
        for (int k = 0; k < len; k++) begin
            ref_mem[k] = sw_base_t'(lo + rand_below(span));
        end
    endtask

    // Gotoh recurrences, best by value, then smallest i+j, then smallest j
    function automatic void model_best(input sw_job_t q, input int n,
                                       output int bs, output int bi, output int bj);
        int hp [0:NPE];
        int fp [0:NPE];
        int hc [0:NPE];
        int ec;
        int fc;
        int pair;
        int bd;
        for (int j = 0; j <= NPE; j++) begin
            hp[j] = 0;
            fp[j] = NEG;
            hc[j] = 0;
        end
        bs = 0;
        bi = 0;
        bj = 0;
        bd = 2;
        for (int i = 1; i <= n; i++) begin
            hc[0] = 0;
            ec = NEG;
            for (int j = 1; j <= NPE; j++) begin
                pair  = (ref_mem[i-1] == q[j-1]) ? `SW_MATCH : -`SW_MISMATCH;
                ec    = imax(hc[j-1] - `SW_GAP_OPEN, ec - `SW_GAP_EXT);
                fc    = imax(hp[j] - `SW_GAP_OPEN, fp[j] - `SW_GAP_EXT);
                hc[j] = imax(imax(0, hp[j-1] + pair), imax(ec, fc));
                fp[j] = fc;
                if (hc[j] > bs || (hc[j] == bs && (i + j < bd || (i + j == bd && j - 1 < bj)))) begin
                    bs = hc[j];
                    bi = i - 1;
                    bj = j - 1;
                    bd = i + j;
                end
            end
            hp = hc;
        end
    endfunction

    task automatic send_job(input sw_job_t q);
        int cnt;
        cnt = 0;
        i_job = q;
        i_job_valid = 1'b1;
        while (!o_job_ready) begin
            tick();
            cnt++;
            assert (cnt < WAIT_LIMIT) else fail_run("timeout while waiting for o_job_ready");
        end
        tick();
        i_job_valid = 1'b0;
        ref_open = 1'b1;
    endtask

    task automatic send_ref(input int gap_max);
        int cnt;
        for (int k = 0; k < ref_len; k++) begin
            repeat (rand_below(gap_max + 1)) tick();
            i_ref = '{base: ref_mem[k], last: (k == ref_len - 1)};
            i_ref_valid = 1'b1;
            cnt = 0;
            while (!o_ref_ready) begin
                tick();
                cnt++;
                assert (cnt < WAIT_LIMIT) else fail_run("timeout while waiting for o_ref_ready");
            end
            tick();
            i_ref_valid = 1'b0;
        end
        ref_open = 1'b0;
    endtask

    // lat counts cycles from the last base transfer to o_res_valid
    task automatic get_result(input int hold_max, output sw_result_t res, output int lat);
        int hold;
        lat = 0;
        while (!o_res_valid) begin
            tick();
            lat++;
            assert (lat < WAIT_LIMIT) else fail_run("timeout while waiting for o_res_valid");
        end
        res = o_res;
        hold = rand_below(hold_max + 1);
        for (int k = 0; k < hold; k++) begin
            tick();
            assert (o_res_valid && o_res == res) else
                fail_run("result changed while the result channel was held back");
            assert (!o_job_ready && !o_ref_ready) else
                fail_run("a ready output went high while the result was waiting");
        end
        i_res_ready = 1'b1;
        tick();
        i_res_ready = 1'b0;
        assert (o_job_ready && !o_res_valid) else
            fail_run("result transfer did not return the DUT to idle");
    endtask

    task automatic run_job(input string name, input sw_job_t q, input int gap_max,
                           input int hold_max, output sw_result_t res);
        int exp_s;
        int exp_r;
        int exp_q;
        int lat;
        model_best(q, ref_len, exp_s, exp_r, exp_q);
        send_job(q);
        send_ref(gap_max);
        get_result(hold_max, res, lat);
        check_int({name, " latency"}, lat, RES_LAT);
        check_int({name, " score"}, int'(res.score), exp_s);
        check_int({name, " ref index"}, int'(res.ref_idx), exp_r);
        check_int({name, " query index"}, int'(res.qry_idx), exp_q);
    endtask

    task automatic test_exact_copy();
        sw_job_t    q;
        sw_result_t res;
        q = random_query();
        fill_ref(20, 0, 4);
        for (int k = 0; k < NPE; k++) begin
            ref_mem[5+k] = q[k];
        end
        run_job("exact copy", q, 0, 0, res);
        check_int("exact copy fixed score", int'(res.score), NPE * `SW_MATCH);
        check_int("exact copy fixed ref index", int'(res.ref_idx), 5 + NPE - 1);
        check_int("exact copy fixed query index", int'(res.qry_idx), NPE - 1);
    endtask

    // query of one base value against a reference without it
    task automatic test_no_common(input string name, input sw_base_t qb);
        sw_job_t    q;
        sw_result_t res;
        for (int k = 0; k < NPE; k++) begin
            q[k] = qb;
        end
        fill_ref(16, 0, 3);
        for (int k = 0; k < ref_len; k++) begin
            if (ref_mem[k] == qb) begin
                ref_mem[k] = 2'd3 - qb;
            end
        end
        run_job(name, q, 0, 0, res);
        check_int({name, " fixed score"}, int'(res.score), 0);
        check_int({name, " fixed ref index"}, int'(res.ref_idx), 0);
        check_int({name, " fixed query index"}, int'(res.qry_idx), 0);
    endtask

    // one base inserted after q[2], q[6] deleted
    task automatic test_indel();
        sw_job_t    q;
        sw_result_t res;
        int         p;
        q = random_query();
        fill_ref(16, 0, 4);
        p = 3;
        for (int k = 0; k < NPE; k++) begin
            if (k == 3) begin
                ref_mem[p] = q[2] + 2'd1;
                p++;
            end
            if (k != 6) begin
                ref_mem[p] = q[k];
                p++;
            end
        end
        run_job("indel", q, 0, 0, res);
    endtask

    task automatic test_random_jobs();
        sw_job_t    q;
        sw_result_t res;
        for (int n = 0; n < 5; n++) begin
            q = random_query();
            fill_ref(1 + rand_below(48), 0, 4);
            run_job($sformatf("random job %0d", n), q, 3, 4, res);
        end
    endtask

    task automatic test_back_to_back();
        test_exact_copy();
        test_no_common("second job", 2'd3);
    endtask

    always @(negedge i_clk) begin
        if (!i_rst) begin
            assert (!o_ref_ready || ref_open) else
                fail_run("o_ref_ready was high outside a job");
        end
    end

    initial begin
        i_rst       = 1'b1;
        i_job_valid = 1'b0;
        i_job       = '0;
        i_ref_valid = 1'b0;
        i_ref       = '0;
        i_res_ready = 1'b0;
        ref_open    = 1'b0;
        ref_len     = 0;
        repeat (10) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        tick();
        assert (o_job_ready && !o_ref_ready && !o_res_valid) else
            fail_run("handshake outputs are wrong after reset");

        test_exact_copy();
        test_no_common("no common base", 2'd0);
        test_indel();
        test_random_jobs();
        test_back_to_back();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- sw_align.f
+incdir+.
sw_pkg.sv
sw_pe.sv
sw_peak_finder.sv
sw_ctrl.sv
sw_align_top.sv
tb_sw_align.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sw_align
FILELIST  ?= sw_align.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
